// File: Bender.yml
package:
  name: div_unit

sources:
  - div_pkg.sv
  - div_decode.sv
  - div_core.sv
  - div_result.sv
  - div_unit.sv
  - target: test
    files:
      - div_unit_properties.sv
      - div_unit_tb.sv

// File: div_core.sv
`default_nettype none

module div_core
    import div_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  issue,
    input  logic  op_signed,
    input  logic  op_word,
    input  xlen_t dividend,
    input  xlen_t divisor,
    output logic  busy,
    output logic  done,
    output xlen_t quotient,
    output xlen_t remainder
);

    div_state_t state;
    count_t     count;
    count_t     count_end;
    logic       load;

    // Operands as captured on issue
    logic  word_q;
    xlen_t dvd_q;
    xlen_t dvs_q;

    // Full width path, partial remainder window is acc_x[127:63]
    logic [2*XLEN-1:0] acc_x;
    logic [XLEN:0]     dvs_x;
    logic [XLEN:0]     sub_x;
    xlen_t             dvd_mag_x;
    xlen_t             quo_x;

    // Word path
    logic [2*WLEN-1:0] acc_w;
    logic [WLEN:0]     dvs_w;
    logic [WLEN:0]     sub_w;
    word_t             dvd_mag_w;
    word_t             quo_w;

    xlen_t mag_quo;
    xlen_t mag_rem;
    logic  neg_quo;
    logic  neg_rem;

    assign count_end = word_q ? CNT_END_WORD : CNT_END_XLEN;
    assign load      = (state == DIV_RUN) && (count == CNT_LOAD);
    assign busy      = (state != DIV_IDLE);
    assign done      = (state == DIV_DONE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= DIV_IDLE;
            count <= '0;
        end else begin
            case (state)
                DIV_IDLE: begin
                    if (issue) begin
                        state <= DIV_RUN;
                        count <= CNT_LOAD;
                    end
                end
                DIV_RUN: begin
                    count <= count + 7'd1;
                    if (count == count_end - 7'd1) begin
                        state <= DIV_DONE;
                    end
                end
                DIV_DONE: begin
                    state <= DIV_IDLE;
                    count <= '0;
                end
                default: begin
                    state <= DIV_IDLE;
                    count <= '0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            word_q <= op_word;
            dvd_q  <= dividend;
            dvs_q  <= divisor;
        end
    end

    // Signedness is held by decode from the issue edge onwards
    assign dvd_mag_x = (op_signed && dvd_q[XLEN-1]) ? -dvd_q : dvd_q;
    assign dvd_mag_w = (op_signed && dvd_q[WLEN-1]) ? -dvd_q[WLEN-1:0] : dvd_q[WLEN-1:0];
    assign dvs_x = {1'b0, (op_signed && dvs_q[XLEN-1]) ? -dvs_q : dvs_q};
    assign dvs_w = {1'b0, (op_signed && dvs_q[WLEN-1]) ? -dvs_q[WLEN-1:0] : dvs_q[WLEN-1:0]};

    // Trial subtraction, a set top bit means the divisor did not fit
    assign sub_x = acc_x[2*XLEN-1:XLEN-1] - dvs_x;
    assign sub_w = acc_w[2*WLEN-1:WLEN-1] - dvs_w;

    always_ff @(posedge clk) begin
        if (load) begin
            acc_x <= {{XLEN{1'b0}}, dvd_mag_x};
            quo_x <= '0;
        end else if (state == DIV_RUN) begin
            if (sub_x[XLEN]) begin
                acc_x <= acc_x << 1;
                quo_x <= {quo_x[XLEN-2:0], 1'b0};
            end else begin
                acc_x <= {sub_x[XLEN-1:0], acc_x[XLEN-2:0], 1'b0};
                quo_x <= {quo_x[XLEN-2:0], 1'b1};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            acc_w <= {{WLEN{1'b0}}, dvd_mag_w};
            quo_w <= '0;
        end else if (state == DIV_RUN) begin
            if (sub_w[WLEN]) begin
                acc_w <= acc_w << 1;
                quo_w <= {quo_w[WLEN-2:0], 1'b0};
            end else begin
                acc_w <= {sub_w[WLEN-1:0], acc_w[WLEN-2:0], 1'b0};
                quo_w <= {quo_w[WLEN-2:0], 1'b1};
            end
        end
    end

    // Last quotient bit comes straight from the final trial subtraction
    always_comb begin
        if (word_q) begin
            mag_quo = {{WLEN{1'b0}}, quo_w[WLEN-2:0], ~sub_w[WLEN]};
            mag_rem = {{WLEN{1'b0}}, sub_w[WLEN] ? acc_w[2*WLEN-2:WLEN-1] : sub_w[WLEN-1:0]};
        end else begin
            mag_quo = {quo_x[XLEN-2:0], ~sub_x[XLEN]};
            mag_rem = sub_x[XLEN] ? acc_x[2*XLEN-2:XLEN-1] : sub_x[XLEN-1:0];
        end
    end

    // Remainder follows the dividend sign
    assign neg_quo = op_signed & (word_q ? (dvd_q[WLEN-1] ^ dvs_q[WLEN-1])
                                         : (dvd_q[XLEN-1] ^ dvs_q[XLEN-1]));
    assign neg_rem = op_signed & (word_q ? dvd_q[WLEN-1] : dvd_q[XLEN-1]);

    always_comb begin
        quotient  = neg_quo ? -mag_quo : mag_quo;
        remainder = neg_rem ? -mag_rem : mag_rem;
        if (word_q) begin
            quotient[XLEN-1:WLEN]  = '0;
            remainder[XLEN-1:WLEN] = '0;
        end
    end

endmodule

`default_nettype wire

// File: div_decode.sv
`default_nettype none

module div_decode
    import div_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    input  funct3_t funct3,
    input  logic    word,
    input  xlen_t   dividend,
    input  xlen_t   divisor,
    input  logic    busy,
    output logic    issue,
    output logic    op_signed,
    output logic    op_rem,
    output logic    op_word,
    output logic    div_zero,
    output logic    overflow,
    output xlen_t   op_dividend
);

    logic dec_signed;
    logic dec_rem;
    logic dvd_min;
    logic dvs_ones;
    logic dec_zero;
    logic dec_overflow;

    // Start is dropped while an operation is in flight
    assign issue = start & ~busy;

    always_comb begin
        case (funct3)
            F3_DIV: begin
                dec_signed = 1'b1;
                dec_rem    = 1'b0;
            end
            F3_DIVU: begin
                dec_signed = 1'b0;
                dec_rem    = 1'b0;
            end
            F3_REM: begin
                dec_signed = 1'b1;
                dec_rem    = 1'b1;
            end
            F3_REMU: begin
                dec_signed = 1'b0;
                dec_rem    = 1'b1;
            end
            default: begin
                dec_signed = 1'b0;
                dec_rem    = 1'b0;
            end
        endcase
    end

    // Special cases at the selected width
    assign dec_zero = word ? (divisor[WLEN-1:0] == '0) : (divisor == '0);
    assign dvd_min  = word ? (dividend[WLEN-1:0] == {1'b1, {(WLEN-1){1'b0}}})
                           : (dividend == {1'b1, {(XLEN-1){1'b0}}});
    assign dvs_ones = word ? (divisor[WLEN-1:0] == '1) : (divisor == '1);
    assign dec_overflow = dec_signed & dvd_min & dvs_ones;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            op_signed <= 1'b0;
            op_rem    <= 1'b0;
            op_word   <= 1'b0;
            div_zero  <= 1'b0;
            overflow  <= 1'b0;
        end else if (issue) begin
            op_signed <= dec_signed;
            op_rem    <= dec_rem;
            op_word   <= word;
            div_zero  <= dec_zero;
            overflow  <= dec_overflow;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            op_dividend <= dividend;
        end
    end

endmodule

`default_nettype wire

// File: div_pkg.sv
`default_nettype none

package div_pkg;

    localparam int XLEN = 64;
    localparam int WLEN = 32;

    typedef logic [XLEN-1:0] xlen_t;
    typedef logic [WLEN-1:0] word_t;

    // M extension funct3 field for the divide group
    typedef logic [2:0] funct3_t;

    localparam funct3_t F3_DIV  = 3'b100;
    localparam funct3_t F3_DIVU = 3'b101;
    localparam funct3_t F3_REM  = 3'b110;
    localparam funct3_t F3_REMU = 3'b111;

    // Divider iteration counter
    typedef logic [6:0] count_t;

    // Operand load step, then the step that shows the last quotient bit
    localparam count_t CNT_LOAD     = 7'd1;
    localparam count_t CNT_END_WORD = 7'd33;
    localparam count_t CNT_END_XLEN = 7'd65;

    typedef enum logic [1:0] {
        DIV_IDLE,
        DIV_RUN,
        DIV_DONE
    } div_state_t;

endpackage

`default_nettype wire

// File: div_result.sv
`default_nettype none

module div_result
    import div_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  done,
    input  xlen_t quotient,
    input  xlen_t remainder,
    input  logic  op_rem,
    input  logic  op_word,
    input  logic  op_signed,
    input  logic  div_zero,
    input  logic  overflow,
    input  xlen_t op_dividend,
    output logic  result_valid,
    output xlen_t result
);

    xlen_t value;

    always_comb begin
        if (div_zero) begin
            // All ones quotient, dividend as remainder
            value = op_rem ? op_dividend : '1;
        end else if (overflow && op_signed) begin
            value = op_rem ? '0 : op_dividend;
        end else begin
            value = op_rem ? remainder : quotient;
        end
        // W forms always return a sign-extended word
        if (op_word) begin
            value = {{WLEN{value[WLEN-1]}}, value[WLEN-1:0]};
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            result_valid <= 1'b0;
            result       <= '0;
        end else begin
            result_valid <= done;
            if (done) begin
                result <= value;
            end
        end
    end

endmodule

`default_nettype wire

// File: div_unit.sv
`default_nettype none

module div_unit
    import div_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    input  funct3_t funct3,
    input  logic    word,
    input  xlen_t   dividend,
    input  xlen_t   divisor,
    output logic    busy,
    output logic    result_valid,
    output xlen_t   result
);

    logic  issue;
    logic  op_signed;
    logic  op_rem;
    logic  op_word;
    logic  div_zero;
    logic  overflow;
    xlen_t op_dividend;
    logic  done;
    xlen_t quotient;
    xlen_t remainder;

    div_decode div_decode_i (
        .clk         (clk),
        .rst         (rst),
        .start       (start),
        .funct3      (funct3),
        .word        (word),
        .dividend    (dividend),
        .divisor     (divisor),
        .busy        (busy),
        .issue       (issue),
        .op_signed   (op_signed),
        .op_rem      (op_rem),
        .op_word     (op_word),
        .div_zero    (div_zero),
        .overflow    (overflow),
        .op_dividend (op_dividend)
    );

    // Core takes the raw operands on the issue cycle
    div_core div_core_i (
        .clk       (clk),
        .rst       (rst),
        .issue     (issue),
        .op_signed (op_signed),
        .op_word   (word),
        .dividend  (dividend),
        .divisor   (divisor),
        .busy      (busy),
        .done      (done),
        .quotient  (quotient),
        .remainder (remainder)
    );

    div_result div_result_i (
        .clk          (clk),
        .rst          (rst),
        .done         (done),
        .quotient     (quotient),
        .remainder    (remainder),
        .op_rem       (op_rem),
        .op_word      (op_word),
        .op_signed    (op_signed),
        .div_zero     (div_zero),
        .overflow     (overflow),
        .op_dividend  (op_dividend),
        .result_valid (result_valid),
        .result       (result)
    );

endmodule

`default_nettype wire

// File: div_unit_properties.sv
`default_nettype none

module div_unit_properties (
    input logic clk,
    input logic rst,
    input logic busy,
    input logic result_valid
);

    result_valid_pulse: assert property (
        @(posedge clk) disable iff (rst) result_valid |=> !result_valid
    ) else $error("result_valid stayed high for more than one cycle");

    valid_not_busy: assert property (
        @(posedge clk) disable iff (rst) !(result_valid && busy)
    ) else $error("result_valid high while busy");

    // busy drops on the edge that raises result_valid
    busy_falls_with_valid: assert property (
        @(posedge clk) disable iff (rst) $rose(result_valid) |-> $fell(busy)
    ) else $error("result_valid rose without busy falling");

endmodule

bind div_unit div_unit_properties div_unit_properties_i (
    .clk          (clk),
    .rst          (rst),
    .busy         (busy),
    .result_valid (result_valid)
);

`default_nettype wire

// File: div_unit_tb.sv
`default_nettype none

module div_unit_tb
    import div_pkg::*;
();

    localparam int N_RANDOM     = 12;
    localparam int WAIT_LIMIT   = 100;
    localparam int QUIET_CYCLES = 70;

    typedef struct packed {
        funct3_t f3;
        logic    word;
        xlen_t   dvd;
        xlen_t   dvs;
        xlen_t   exp;
        logic    poke;
    } row_t;

    logic    clk;
    logic    rst;
    logic    start;
    funct3_t funct3;
    logic    word;
    xlen_t   dividend;
    xlen_t   divisor;
    logic    busy;
    logic    result_valid;
    xlen_t   result;

    row_t rows[$];
    int   errors;
    int   n_poke;
    logic table_ready;

    div_unit div_unit_i (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .funct3       (funct3),
        .word         (word),
        .dividend     (dividend),
        .divisor      (divisor),
        .busy         (busy),
        .result_valid (result_valid),
        .result       (result)
    );

    always #2 clk = ~clk;

    // RISC-V M extension rules, including divide by zero and signed overflow
    function automatic xlen_t expected_result(funct3_t f3, logic w, xlen_t a, xlen_t b);
        logic                   is_signed;
        logic                   is_rem;
        logic signed [XLEN-1:0] sa;
        logic signed [XLEN-1:0] sb;
        logic signed [WLEN-1:0] swa;
        logic signed [WLEN-1:0] swb;
        word_t                  wq;
        word_t                  wr;
        xlen_t                  q;
        xlen_t                  r;
        is_signed = (f3 == F3_DIV) || (f3 == F3_REM);
        is_rem    = (f3 == F3_REM) || (f3 == F3_REMU);
        sa  = a;
        sb  = b;
        swa = a[WLEN-1:0];
        swb = b[WLEN-1:0];
        if (w) begin
            if (b[WLEN-1:0] == '0) begin
                wq = '1;
                wr = a[WLEN-1:0];
            end else if (is_signed && a[WLEN-1:0] == 32'h8000_0000 && b[WLEN-1:0] == '1) begin
                wq = a[WLEN-1:0];
                wr = '0;
            end else if (is_signed) begin
                wq = swa / swb;
                wr = swa % swb;
            end else begin
                wq = a[WLEN-1:0] / b[WLEN-1:0];
                wr = a[WLEN-1:0] % b[WLEN-1:0];
            end
            q = {{WLEN{wq[WLEN-1]}}, wq};
            r = {{WLEN{wr[WLEN-1]}}, wr};
        end else begin
            if (b == '0) begin
                q = '1;
                r = a;
            end else if (is_signed && a == 64'h8000_0000_0000_0000 && b == '1) begin
                q = a;
                r = '0;
            end else if (is_signed) begin
                q = sa / sb;
                r = sa % sb;
            end else begin
                q = a / b;
                r = a % b;
            end
        end
        return is_rem ? r : q;
    endfunction

    task automatic check_xlen(input string name, input xlen_t got, input xlen_t exp);
        if (got !== exp) begin
            $display("Error at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error at %0t: %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic add_row(funct3_t f3, logic w, xlen_t a, xlen_t b, xlen_t exp, logic poke);
        rows.push_back('{f3, w, a, b, exp, poke});
        if (poke) begin
            n_poke++;
        end
    endtask

    task automatic build_table();
        funct3_t f3;
        logic    w;
        xlen_t   a;
        xlen_t   b;
        // funct3, word, dividend, divisor, expected, start again while busy
        add_row(F3_DIV,  0, 64'd100, 64'd7, 64'h0000_0000_0000_000e, 1);
        add_row(F3_DIV,  0, -64'sd100, 64'd7, 64'hffff_ffff_ffff_fff2, 0);
        add_row(F3_REM,  0, -64'sd100, 64'd7, 64'hffff_ffff_ffff_fffe, 0);
        add_row(F3_REM,  0, 64'd100, -64'sd7, 64'h0000_0000_0000_0002, 0);
        add_row(F3_DIV,  0, -64'sd100, -64'sd7, 64'h0000_0000_0000_000e, 0);
        add_row(F3_REM,  0, -64'sd100, -64'sd7, 64'hffff_ffff_ffff_fffe, 0);
        add_row(F3_DIVU, 0, '1, 64'd3, 64'h5555_5555_5555_5555, 0);
        add_row(F3_REMU, 0, '1, 64'd10, 64'h0000_0000_0000_0005, 0);
        // Word forms with junk in the upper halves
        add_row(F3_DIV,  1, 64'hdead_beef_ffff_ff9c, 64'h1234_5678_0000_0007,
                64'hffff_ffff_ffff_fff2, 1);
        add_row(F3_DIVU, 1, 64'h0000_0001_ffff_fffe, 64'hffff_ffff_0000_0001,
                64'hffff_ffff_ffff_fffe, 0);
        add_row(F3_REMU, 1, 64'h0000_0000_8000_0007, 64'h10, 64'h0000_0000_0000_0007, 0);
        add_row(F3_REM,  1, 64'hffff_ffff_ffff_ff9c, 64'd7, 64'hffff_ffff_ffff_fffe, 0);
        // Divide by zero
        add_row(F3_DIV,  0, 64'd1234, 64'd0, 64'hffff_ffff_ffff_ffff, 0);
        add_row(F3_REM,  0, 64'd1234, 64'd0, 64'h0000_0000_0000_04d2, 0);
        add_row(F3_DIVU, 1, 64'd5, 64'habcd_0000_0000_0000, 64'hffff_ffff_ffff_ffff, 0);
        add_row(F3_REM,  1, 64'h0000_0000_8000_0001, 64'd0, 64'hffff_ffff_8000_0001, 0);
        // Signed overflow
        add_row(F3_DIV,  0, 64'h8000_0000_0000_0000, '1, 64'h8000_0000_0000_0000, 0);
        add_row(F3_REM,  0, 64'h8000_0000_0000_0000, '1, 64'h0000_0000_0000_0000, 0);
        add_row(F3_DIV,  1, 64'h0000_0000_8000_0000, 64'hffff_ffff, 64'hffff_ffff_8000_0000, 0);
        add_row(F3_REM,  1, 64'h0000_0000_8000_0000, 64'hffff_ffff, 64'h0000_0000_0000_0000, 0);
        for (int k = 0; k < N_RANDOM; k++) begin
            f3 = funct3_t'(4 + ($urandom % 4));
            w  = 1'($urandom % 2);
            a  = {$urandom, $urandom};
            // Shift spreads the divisor magnitudes
            b  = {$urandom, $urandom} >> ($urandom % 64);
            add_row(f3, w, a, b, expected_result(f3, w, a, b), 1'b0);
        end
    endtask

    task automatic run_row(input int idx);
        row_t r;
        int   cycles;
        int   extra;
        int   errs_before;
        logic seen;
        r = rows[idx];
        errs_before = errors;
        @(posedge clk);
        start    <= 1'b1;
        funct3   <= r.f3;
        word     <= r.word;
        dividend <= r.dvd;
        divisor  <= r.dvs;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < WAIT_LIMIT) begin
            @(posedge clk);
            if (r.poke && cycles == 4) begin
                // Must be dropped, the unit is busy
                start    <= 1'b1;
                dividend <= ~r.dvd;
                divisor  <= ~r.dvs;
            end else begin
                start <= 1'b0;
            end
            @(negedge clk);
            cycles++;
            seen = result_valid;
        end
        if (!seen) begin
            $display("Test %0d never raised result_valid within %0d cycles", idx, WAIT_LIMIT);
            errors++;
        end else begin
            if (cycles != (r.word ? 34 : 66)) begin
                $display("Error at %0t: latency got %0d expected %0d",
                         $time, cycles, r.word ? 34 : 66);
                errors++;
            end
            check_xlen("result", result, r.exp);
            check_bit("busy", busy, 1'b0);
        end
        if (r.poke) begin
            extra = 0;
            repeat (QUIET_CYCLES) begin
                @(negedge clk);
                if (result_valid) begin
                    extra++;
                end
            end
            if (extra != 0) begin
                $display("Test %0d gave %0d extra result_valid pulses after a dropped start",
                         idx, extra);
                errors++;
            end
        end
        $display("test %0d funct3=%b word=%b: %s", idx, r.f3, r.word,
                 (errors == errs_before) ? "ok" : "failed");
    endtask

    initial begin
        int limit;
        wait (table_ready);
        limit = (rows.size() + n_poke) * 70 + 200;
        repeat (limit) @(posedge clk);
        $display("Watchdog expired after %0d cycles before the tests completed", limit);
        $display("Test failures found");
        $finish;
    end

    initial begin
        void'($urandom(32'had5d_b001));
        clk         = 1'b0;
        rst         = 1'b1;
        start       = 1'b0;
        funct3      = F3_DIV;
        word        = 1'b0;
        dividend    = '0;
        divisor     = '0;
        errors      = 0;
        n_poke      = 0;
        table_ready = 1'b0;
        build_table();
        table_ready = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_bit("busy", busy, 1'b0);
        check_bit("result_valid", result_valid, 1'b0);
        check_xlen("result", result, '0);
        $display("test reset: %s", (errors == 0) ? "ok" : "failed");
        for (int i = 0; i < rows.size(); i++) begin
            run_row(i);
        end
        $display("%0d tests run, %0d errors", rows.size() + 1, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog.f
div_pkg.sv
div_decode.sv
div_core.sv
div_result.sv
div_unit.sv
div_unit_properties.sv
div_unit_tb.sv
